/* src/spi_bus_pkg.sv */
package spi_bus_pkg;

  // APB byte address
  typedef logic [31:0] addr_t;

  // APB and Wishbone data word
  typedef logic [31:0] data_t;

  // One strobe per byte lane
  typedef logic [3:0] strb_t;

  // Register address seen by the SPI master
  typedef logic [4:0] wb_adr_t;

  // Execute-in-place window into the flash
  localparam addr_t FLASH_BASE_DEFAULT = 32'h3000_0000;
  localparam addr_t FLASH_END_DEFAULT  = 32'h3FFF_FFFF;

  // Direct window onto the SPI master registers
  localparam addr_t SPI_BASE_DEFAULT = 32'h1000_1000;
  localparam addr_t SPI_END_DEFAULT  = 32'h1000_1FFF;

endpackage

/* src/spi_core_pkg.sv */
package spi_core_pkg;

  // Register offsets of the SPI master
  localparam logic [4:0] REG_RX0_TX0 = 5'h00;
  localparam logic [4:0] REG_RX1_TX1 = 5'h04;
  localparam logic [4:0] REG_CTRL    = 5'h10;
  localparam logic [4:0] REG_DIVIDER = 5'h14;
  localparam logic [4:0] REG_SS      = 5'h18;

  // Transfer length in bits
  // 0 and anything above 64 both mean 64
  typedef logic [6:0] char_len_t;

  // Half period of sck is divider+1 clocks
  typedef logic [15:0] divider_t;

  // Full shift register contents
  typedef logic [63:0] shift_t;

  // CTRL layout, char_len sits in the low bits
  localparam int CTRL_GO_BSY = 8;
  localparam int CTRL_IE     = 12;

  // Standard read opcode of a serial flash
  localparam logic [7:0] FLASH_READ_CMD = 8'h03;

  // Opcode, 24-bit address and 32 data bits
  localparam char_len_t XIP_CHAR_LEN = 7'd64;

endpackage

/* src/spi_shift_engine.sv */
`timescale 1ns/1ns

module spi_shift_engine (
  input  logic                    clock_i,
  input  logic                    reset_i,
  input  logic                    start_i,
  input  spi_core_pkg::shift_t    tx_data_i,
  input  spi_core_pkg::char_len_t char_len_i,
  input  spi_core_pkg::divider_t  divider_i,
  input  logic                    miso_i,
  output logic                    busy_o,
  output logic                    done_o,
  output spi_core_pkg::shift_t    rx_data_o,
  output logic                    sck_o,
  output logic                    mosi_o
);
  import spi_core_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    LOW_HALF,
    HIGH_HALF
  } state_t;

  state_t    state_q;
  divider_t  div_cnt_q;
  char_len_t bits_left_q;
  char_len_t len;
  shift_t    shift_q;
  logic      half_end;

  // Zero or oversize length runs the full 64 bits
  assign len = ((char_len_i == '0) || (char_len_i > char_len_t'(64))) ?
               char_len_t'(64) : char_len_i;

  // Each sck half lasts divider+1 clocks
  assign half_end = (div_cnt_q == divider_i);
  assign busy_o   = (state_q != IDLE);

  always_ff @(posedge clock_i or posedge reset_i) begin
    if (reset_i) begin
      state_q     <= IDLE;
      div_cnt_q   <= '0;
      bits_left_q <= '0;
      sck_o       <= 1'b0;
      mosi_o      <= 1'b0;
      done_o      <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_i) begin
            // First bit is set up before the first rising edge
            state_q     <= LOW_HALF;
            div_cnt_q   <= '0;
            bits_left_q <= len;
            mosi_o      <= tx_data_i[63];
          end
        end
        LOW_HALF: begin
          if (half_end) begin
            state_q   <= HIGH_HALF;
            div_cnt_q <= '0;
            sck_o     <= 1'b1;
          end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
          end
        end
        HIGH_HALF: begin
          if (half_end) begin
            // Falling edge
            sck_o       <= 1'b0;
            div_cnt_q   <= '0;
            bits_left_q <= bits_left_q - 1'b1;
            if (bits_left_q == char_len_t'(1)) begin
              state_q <= IDLE;
              done_o  <= 1'b1;
              mosi_o  <= 1'b0;
            end else begin
              state_q <= LOW_HALF;
              mosi_o  <= shift_q[62];
            end
          end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // MSB-first shift out, receive into the low end
  always_ff @(posedge clock_i) begin
    if ((state_q == IDLE) && start_i) begin
      shift_q <= tx_data_i;
    end else if ((state_q == HIGH_HALF) && half_end) begin
      shift_q <= {shift_q[62:0], 1'b0};
    end
    // Sample MISO as sck rises
    if ((state_q == LOW_HALF) && half_end) begin
      rx_data_o <= {rx_data_o[62:0], miso_i};
    end
  end

  // The register block holds start back while busy
  a_no_start_busy: assert property (@(posedge clock_i) disable iff (reset_i)
    start_i |-> !busy_o);

endmodule

/* src/spi_master_wb.sv */
`timescale 1ns/1ns

module spi_master_wb #(
  parameter int SS_NUM = 8
) (
  input  logic                 clock_i,
  input  logic                 reset_i,
  // Wishbone slave side
  input  spi_bus_pkg::wb_adr_t wb_adr_i,
  input  spi_bus_pkg::data_t   wb_dat_i,
  input  spi_bus_pkg::strb_t   wb_sel_i,
  input  logic                 wb_we_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_cyc_i,
  output spi_bus_pkg::data_t   wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  output logic                 irq_o,
  // SPI pins
  output logic [SS_NUM-1:0]    spi_ss_o,
  output logic                 spi_sck_o,
  output logic                 spi_mosi_o,
  input  logic                 spi_miso_i
);
  import spi_bus_pkg::*;
  import spi_core_pkg::*;

  shift_t            tx_q;
  shift_t            rx_data;
  char_len_t         char_len_q;
  divider_t          divider_q;
  logic [SS_NUM-1:0] ss_q;
  logic              ie_q;
  logic              start_q;
  logic              busy;
  logic              done;
  logic              access;
  logic              addr_ok;
  logic              wr;
  logic              ctrl_wr;
  logic              busy_rd;
  data_t             ctrl_rd;

  // New request, not the tail of one already answered
  assign access  = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o;
  assign addr_ok = wb_adr_i inside {REG_RX0_TX0, REG_RX1_TX1, REG_CTRL, REG_DIVIDER, REG_SS};
  assign wr      = access && addr_ok && wb_we_i;
  assign ctrl_wr = wr && (wb_adr_i == REG_CTRL);

  // Busy already while start is on its way to the engine
  assign busy_rd = busy || start_q;

  // Selects are active low
  assign spi_ss_o = ~ss_q;

  always_comb begin
    ctrl_rd                  = '0;
    ctrl_rd[6:0]             = char_len_q;
    ctrl_rd[CTRL_GO_BSY]     = busy_rd;
    ctrl_rd[CTRL_IE]         = ie_q;
  end

  always_ff @(posedge clock_i or posedge reset_i) begin
    if (reset_i) begin
      wb_ack_o   <= 1'b0;
      wb_err_o   <= 1'b0;
      start_q    <= 1'b0;
      char_len_q <= '0;
      ie_q       <= 1'b0;
      divider_q  <= '0;
      ss_q       <= '0;
      irq_o      <= 1'b0;
    end else begin
      // Answer one cycle after the request is sampled
      wb_ack_o <= access && addr_ok;
      wb_err_o <= access && !addr_ok;
      start_q  <= 1'b0;
      if (ctrl_wr && !busy_rd) begin
        if (wb_sel_i[0]) begin
          char_len_q <= wb_dat_i[6:0];
        end
        if (wb_sel_i[1]) begin
          ie_q    <= wb_dat_i[CTRL_IE];
          start_q <= wb_dat_i[CTRL_GO_BSY];
        end
      end
      if (wr && !busy_rd && (wb_adr_i == REG_DIVIDER)) begin
        if (wb_sel_i[0]) divider_q[7:0] <= wb_dat_i[7:0];
        if (wb_sel_i[1]) divider_q[15:8] <= wb_dat_i[15:8];
      end
      // SS stays writable during a transfer
      if (wr && (wb_adr_i == REG_SS)) begin
        for (int i = 0; i < SS_NUM; i++) begin
          if (wb_sel_i[i / 8]) ss_q[i] <= wb_dat_i[i];
        end
      end
      // End of transfer beats a clearing write
      if (done && ie_q) begin
        irq_o <= 1'b1;
      end else if (ctrl_wr) begin
        irq_o <= 1'b0;
      end
    end
  end

  // TX data and read mux
  always_ff @(posedge clock_i) begin
    if (wr && !busy_rd) begin
      for (int b = 0; b < 4; b++) begin
        if (wb_sel_i[b] && (wb_adr_i == REG_RX0_TX0)) tx_q[8*b +: 8] <= wb_dat_i[8*b +: 8];
        if (wb_sel_i[b] && (wb_adr_i == REG_RX1_TX1)) tx_q[32+8*b +: 8] <= wb_dat_i[8*b +: 8];
      end
    end
    if (access && !wb_we_i) begin
      case (wb_adr_i)
        REG_RX0_TX0: wb_dat_o <= rx_data[31:0];
        REG_RX1_TX1: wb_dat_o <= rx_data[63:32];
        REG_CTRL:    wb_dat_o <= ctrl_rd;
        REG_DIVIDER: wb_dat_o <= data_t'(divider_q);
        REG_SS:      wb_dat_o <= data_t'(ss_q);
        default:     wb_dat_o <= '0;
      endcase
    end
  end

  spi_shift_engine engine_i (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .start_i    (start_q),
    .tx_data_i  (tx_q),
    .char_len_i (char_len_q),
    .divider_i  (divider_q),
    .miso_i     (spi_miso_i),
    .busy_o     (busy),
    .done_o     (done),
    .rx_data_o  (rx_data),
    .sck_o      (spi_sck_o),
    .mosi_o     (spi_mosi_o)
  );

  // One response per request, never both kinds
  a_single_resp: assert property (@(posedge clock_i) disable iff (reset_i)
    (wb_ack_o || wb_err_o) |-> !(wb_ack_o && wb_err_o) ##1 !(wb_ack_o || wb_err_o));

endmodule

/* src/apb_xip_bridge.sv */
`timescale 1ns/1ns

module apb_xip_bridge #(
  parameter spi_bus_pkg::addr_t     FLASH_BASE  = spi_bus_pkg::FLASH_BASE_DEFAULT,
  parameter spi_bus_pkg::addr_t     FLASH_END   = spi_bus_pkg::FLASH_END_DEFAULT,
  parameter spi_bus_pkg::addr_t     SPI_BASE    = spi_bus_pkg::SPI_BASE_DEFAULT,
  parameter spi_bus_pkg::addr_t     SPI_END     = spi_bus_pkg::SPI_END_DEFAULT,
  parameter spi_core_pkg::divider_t XIP_DIVIDER = 16'd1
) (
  input  logic                 clock_i,
  input  logic                 reset_i,
  // APB slave side
  input  spi_bus_pkg::addr_t   paddr_i,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  spi_bus_pkg::data_t   pwdata_i,
  input  spi_bus_pkg::strb_t   pstrb_i,
  output logic                 pready_o,
  output spi_bus_pkg::data_t   prdata_o,
  output logic                 pslverr_o,
  // Wishbone master side
  output spi_bus_pkg::wb_adr_t wb_adr_o,
  output spi_bus_pkg::data_t   wb_dat_o,
  input  spi_bus_pkg::data_t   wb_dat_i,
  output spi_bus_pkg::strb_t   wb_sel_o,
  output logic                 wb_we_o,
  output logic                 wb_stb_o,
  output logic                 wb_cyc_o,
  input  logic                 wb_ack_i,
  input  logic                 wb_err_i
);
  import spi_bus_pkg::*;
  import spi_core_pkg::*;

  typedef enum logic [3:0] {
    IDLE,
    REG_ACCESS,
    SEND_CMD,
    SET_DIVIDER,
    SET_SS,
    GO_BUSY,
    POLL,
    READ_RX,
    RELEASE_SS,
    RESPOND
  } state_t;

  state_t  state_q;
  logic    access_start;
  logic    hit_flash;
  logic    hit_spi;
  logic    xip_step;
  logic    step_launch;
  logic    wb_resp;
  logic    xip_err_q;
  addr_t   flash_off;
  wb_adr_t step_adr;
  data_t   step_dat;
  logic    step_we;

  // First access-phase cycle of an APB transfer
  assign access_start = (state_q == IDLE) && psel_i && penable_i;

  // Windows decoded straight from the held paddr
  assign hit_flash = (paddr_i >= FLASH_BASE) && (paddr_i <= FLASH_END);
  assign hit_spi   = (paddr_i >= SPI_BASE) && (paddr_i <= SPI_END);
  assign flash_off = paddr_i - FLASH_BASE;

  // XIP steps each run one Wishbone cycle
  assign xip_step    = state_q inside {SEND_CMD, SET_DIVIDER, SET_SS, GO_BUSY,
                                       POLL, READ_RX, RELEASE_SS};
  // Bus is free again one cycle after a response
  assign step_launch = xip_step && !wb_cyc_o;
  assign wb_resp     = wb_cyc_o && (wb_ack_i || wb_err_i);

  // Register access for the current XIP step
  always_comb begin
    step_adr = REG_CTRL;
    step_dat = '0;
    step_we  = 1'b0;
    case (state_q)
      SEND_CMD: begin
        // Opcode first, then the 24-bit flash address
        step_adr = REG_RX1_TX1;
        step_dat = {FLASH_READ_CMD, flash_off[23:0]};
        step_we  = 1'b1;
      end
      SET_DIVIDER: begin
        step_adr = REG_DIVIDER;
        step_dat = data_t'(XIP_DIVIDER);
        step_we  = 1'b1;
      end
      SET_SS: begin
        // Flash sits on select 0
        step_adr = REG_SS;
        step_dat = data_t'(1);
        step_we  = 1'b1;
      end
      GO_BUSY: begin
        step_adr              = REG_CTRL;
        step_dat[6:0]         = XIP_CHAR_LEN;
        step_dat[CTRL_GO_BSY] = 1'b1;
        step_we               = 1'b1;
      end
      // Poll reads CTRL with the defaults above
      POLL: step_adr = REG_CTRL;
      READ_RX: step_adr = REG_RX0_TX0;
      RELEASE_SS: begin
        step_adr = REG_SS;
        step_we  = 1'b1;
      end
      default: ;
    endcase
  end

  // Sequencer and handshake state
  always_ff @(posedge clock_i or posedge reset_i) begin
    if (reset_i) begin
      state_q   <= IDLE;
      wb_cyc_o  <= 1'b0;
      wb_stb_o  <= 1'b0;
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
      xip_err_q <= 1'b0;
    end else begin
      // pready is a single-cycle pulse
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
      if (step_launch) begin
        wb_cyc_o <= 1'b1;
        wb_stb_o <= 1'b1;
      end else if (wb_resp) begin
        wb_cyc_o <= 1'b0;
        wb_stb_o <= 1'b0;
      end
      if (wb_resp && wb_err_i) begin
        xip_err_q <= 1'b1;
      end
      case (state_q)
        IDLE: begin
          if (access_start) begin
            xip_err_q <= 1'b0;
            if (hit_spi) begin
              // Register window goes straight onto the bus
              wb_cyc_o <= 1'b1;
              wb_stb_o <= 1'b1;
              state_q  <= REG_ACCESS;
            end else if (hit_flash && !pwrite_i) begin
              state_q <= SEND_CMD;
            end else begin
              // Flash write or unmapped address
              pready_o  <= 1'b1;
              pslverr_o <= 1'b1;
              state_q   <= RESPOND;
            end
          end
        end
        REG_ACCESS: begin
          if (wb_resp) begin
            pready_o  <= 1'b1;
            pslverr_o <= wb_err_i;
            state_q   <= RESPOND;
          end
        end
        SEND_CMD: if (wb_resp) state_q <= SET_DIVIDER;
        SET_DIVIDER: if (wb_resp) state_q <= SET_SS;
        SET_SS: if (wb_resp) state_q <= GO_BUSY;
        GO_BUSY: if (wb_resp) state_q <= POLL;
        POLL: begin
          // Stay until GO_BSY reads back clear
          if (wb_resp && (wb_err_i || !wb_dat_i[CTRL_GO_BSY])) begin
            state_q <= READ_RX;
          end
        end
        READ_RX: if (wb_resp) state_q <= RELEASE_SS;
        RELEASE_SS: begin
          // Select is released before the APB response
          if (wb_resp) begin
            pready_o  <= 1'b1;
            pslverr_o <= xip_err_q || wb_err_i;
            state_q   <= RESPOND;
          end
        end
        RESPOND: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Bus payload only means something while cyc is high
  always_ff @(posedge clock_i) begin
    if (access_start && hit_spi) begin
      wb_adr_o <= paddr_i[$bits(wb_adr_t)-1:0];
      wb_dat_o <= pwdata_i;
      wb_sel_o <= pstrb_i;
      wb_we_o  <= pwrite_i;
    end else if (step_launch) begin
      wb_adr_o <= step_adr;
      wb_dat_o <= step_dat;
      wb_sel_o <= '1;
      wb_we_o  <= step_we;
    end
    // Register read data or the RX0 flash word
    if (wb_resp && (state_q inside {REG_ACCESS, READ_RX})) begin
      prdata_o <= wb_dat_i;
    end
  end

  // Cycle and strobe fall together right after the response
  a_resp_release: assert property (@(posedge clock_i) disable iff (reset_i)
    wb_cyc_o && (wb_ack_i || wb_err_i) |=> !wb_cyc_o && !wb_stb_o);

  // Request stays put until the slave answers
  a_bus_hold: assert property (@(posedge clock_i) disable iff (reset_i)
    wb_cyc_o && !wb_ack_i && !wb_err_i |=>
      wb_cyc_o && $stable({wb_adr_o, wb_dat_o, wb_sel_o, wb_we_o}));

endmodule

/* src/spi_xip_top.sv */
`timescale 1ns/1ns

module spi_xip_top #(
  parameter spi_bus_pkg::addr_t     FLASH_BASE  = spi_bus_pkg::FLASH_BASE_DEFAULT,
  parameter spi_bus_pkg::addr_t     FLASH_END   = spi_bus_pkg::FLASH_END_DEFAULT,
  parameter spi_bus_pkg::addr_t     SPI_BASE    = spi_bus_pkg::SPI_BASE_DEFAULT,
  parameter spi_bus_pkg::addr_t     SPI_END     = spi_bus_pkg::SPI_END_DEFAULT,
  parameter spi_core_pkg::divider_t XIP_DIVIDER = 16'd1,
  parameter int                     SS_NUM      = 8
) (
  input  logic               clock_i,
  input  logic               reset_i,
  // APB
  input  spi_bus_pkg::addr_t paddr_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  spi_bus_pkg::data_t pwdata_i,
  input  spi_bus_pkg::strb_t pstrb_i,
  output logic               pready_o,
  output spi_bus_pkg::data_t prdata_o,
  output logic               pslverr_o,
  // SPI pins
  output logic               spi_sck_o,
  output logic [SS_NUM-1:0]  spi_ss_o,
  output logic               spi_mosi_o,
  input  logic               spi_miso_i,
  output logic               spi_irq_o
);
  import spi_bus_pkg::*;

  // Wishbone between bridge and SPI master
  wb_adr_t wb_adr;
  data_t   wb_dat_w;
  data_t   wb_dat_r;
  strb_t   wb_sel;
  logic    wb_we;
  logic    wb_stb;
  logic    wb_cyc;
  logic    wb_ack;
  logic    wb_err;

  apb_xip_bridge #(
    .FLASH_BASE  (FLASH_BASE),
    .FLASH_END   (FLASH_END),
    .SPI_BASE    (SPI_BASE),
    .SPI_END     (SPI_END),
    .XIP_DIVIDER (XIP_DIVIDER)
  ) bridge_i (
    .clock_i   (clock_i),
    .reset_i   (reset_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .pready_o  (pready_o),
    .prdata_o  (prdata_o),
    .pslverr_o (pslverr_o),
    .wb_adr_o  (wb_adr),
    .wb_dat_o  (wb_dat_w),
    .wb_dat_i  (wb_dat_r),
    .wb_sel_o  (wb_sel),
    .wb_we_o   (wb_we),
    .wb_stb_o  (wb_stb),
    .wb_cyc_o  (wb_cyc),
    .wb_ack_i  (wb_ack),
    .wb_err_i  (wb_err)
  );

  spi_master_wb #(
    .SS_NUM (SS_NUM)
  ) spi_i (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .wb_adr_i   (wb_adr),
    .wb_dat_i   (wb_dat_w),
    .wb_sel_i   (wb_sel),
    .wb_we_i    (wb_we),
    .wb_stb_i   (wb_stb),
    .wb_cyc_i   (wb_cyc),
    .wb_dat_o   (wb_dat_r),
    .wb_ack_o   (wb_ack),
    .wb_err_o   (wb_err),
    .irq_o      (spi_irq_o),
    .spi_ss_o   (spi_ss_o),
    .spi_sck_o  (spi_sck_o),
    .spi_mosi_o (spi_mosi_o),
    .spi_miso_i (spi_miso_i)
  );

endmodule

/* testbench/spi_flash_model.sv */
`timescale 1ns/1ns

module spi_flash_model (
  input  logic sck_i,
  input  logic ss_n_i,
  input  logic mosi_i,
  output logic miso_o
);

  logic [31:0] header_q;
  logic [23:0] start_addr_q;
  logic [7:0]  cur_byte;
  int          rx_bits;
  int          tx_bits;
  logic        reading;

  // Data byte at a flash offset
  function automatic logic [7:0] byte_at(input logic [23:0] x);
    return x[7:0] ^ x[15:8] ^ 8'h5A;
  endfunction

  initial begin
    header_q     = '0;
    start_addr_q = '0;
    rx_bits      = 0;
    tx_bits      = 0;
    reading      = 1'b0;
    miso_o       = 1'b0;
  end

  // Opcode and address come in on rising sck, MSB first
  always @(posedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      rx_bits <= 0;
      reading <= 1'b0;
    end else begin
      header_q <= {header_q[30:0], mosi_i};
      rx_bits  <= rx_bits + 1;
      // Last header bit is on mosi right now
      if (rx_bits == 31) begin
        reading      <= (header_q[30:23] == 8'h03);
        start_addr_q <= {header_q[22:0], mosi_i};
      end
    end
  end

  // Next data bit on falling sck, ready before the master samples
  assign cur_byte = byte_at(start_addr_q + 24'(tx_bits / 8));

  always @(negedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      tx_bits <= 0;
      miso_o  <= 1'b0;
    end else if (reading) begin
      miso_o  <= cur_byte[7 - (tx_bits % 8)];
      tx_bits <= tx_bits + 1;
    end
  end

endmodule

/* testbench/spi_xip_tb.sv */
`timescale 1ns/1ns

module spi_xip_tb;
  import spi_bus_pkg::*;
  import spi_core_pkg::*;

  localparam int SS_NUM         = 8;
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int XIP_READS      = 16;

  logic              clock;
  logic              reset;
  addr_t             paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  data_t             pwdata;
  strb_t             pstrb;
  logic              pready_o;
  data_t             prdata_o;
  logic              pslverr_o;
  logic              spi_sck;
  logic [SS_NUM-1:0] spi_ss;
  logic              spi_mosi;
  logic              spi_miso;
  logic              spi_irq;
  logic [15:0]       lfsr_state;
  int                cycle_count = 0;

  spi_xip_top #(
    .XIP_DIVIDER (16'd1),
    .SS_NUM      (SS_NUM)
  ) dut_i (
    .clock_i    (clock),
    .reset_i    (reset),
    .paddr_i    (paddr),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .pwdata_i   (pwdata),
    .pstrb_i    (pstrb),
    .pready_o   (pready_o),
    .prdata_o   (prdata_o),
    .pslverr_o  (pslverr_o),
    .spi_sck_o  (spi_sck),
    .spi_ss_o   (spi_ss),
    .spi_mosi_o (spi_mosi),
    .spi_miso_i (spi_miso),
    .spi_irq_o  (spi_irq)
  );

  // Flash hangs on select 0
  spi_flash_model flash_i (
    .sck_i  (spi_sck),
    .ss_n_i (spi_ss[0]),
    .mosi_i (spi_mosi),
    .miso_o (spi_miso)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Hang guard
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: no end of test after %0d clock cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input data_t got, input data_t exp);
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // One LFSR step per bit
  task automatic take_random_bits(input int n, output data_t value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  // Four flash bytes from off upward with the first in the top lane
  function automatic data_t flash_word(input logic [23:0] off);
    data_t       w;
    logic [23:0] x;
    w = '0;
    for (int i = 0; i < 4; i++) begin
      x = off + 24'(i);
      w = {w[23:0], x[7:0] ^ x[15:8] ^ 8'h5A};
    end
    return w;
  endfunction

  // Setup phase, access phase, then wait on pready
  task automatic apb_transfer(input logic write, input addr_t addr, input data_t wdata,
                              input strb_t strb, output data_t rdata, output logic err);
    @(negedge clock);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    pstrb   = strb;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clock);
    penable = 1'b1;
    do begin
      @(negedge clock);
    end while (!pready_o);
    rdata   = prdata_o;
    err     = pslverr_o;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input addr_t addr, input data_t wdata, output logic err);
    data_t unused;
    apb_transfer(1'b1, addr, wdata, 4'hF, unused, err);
  endtask

  task automatic apb_read(input addr_t addr, output data_t rdata, output logic err);
    apb_transfer(1'b0, addr, '0, 4'h0, rdata, err);
  endtask

  function automatic addr_t reg_addr(input logic [4:0] offset);
    return SPI_BASE_DEFAULT + addr_t'(offset);
  endfunction

  task automatic after_reset_state();
    check_value("pready_o", data_t'(pready_o), 32'h0);
    check_value("spi_sck_o", data_t'(spi_sck), 32'h0);
    check_value("spi_mosi_o", data_t'(spi_mosi), 32'h0);
    check_value("spi_irq_o", data_t'(spi_irq), 32'h0);
    check_value("spi_ss_o", data_t'(spi_ss), 32'hFF);
  endtask

  task automatic register_access();
    data_t rd;
    logic  err;
    apb_write(reg_addr(REG_DIVIDER), 32'h0000_0003, err);
    check_value("pslverr_o", data_t'(err), 32'h0);
    apb_read(reg_addr(REG_DIVIDER), rd, err);
    check_value("prdata_o (DIVIDER)", rd, 32'h0000_0003);
    // Select 0 active drives its pin low
    apb_write(reg_addr(REG_SS), 32'h0000_0001, err);
    apb_read(reg_addr(REG_SS), rd, err);
    check_value("prdata_o (SS)", rd, 32'h0000_0001);
    check_value("spi_ss_o", data_t'(spi_ss), 32'hFE);
    // char_len 64 and ie with GO_BSY left clear
    apb_write(reg_addr(REG_CTRL), 32'h0000_1040, err);
    apb_read(reg_addr(REG_CTRL), rd, err);
    check_value("prdata_o (CTRL)", rd, 32'h0000_1040);
    check_value("pslverr_o", data_t'(err), 32'h0);
    // Hole in the register map
    apb_read(reg_addr(5'h08), rd, err);
    check_value("pslverr_o", data_t'(err), 32'h1);
    apb_write(reg_addr(REG_SS), 32'h0, err);
    check_value("spi_ss_o", data_t'(spi_ss), 32'hFF);
  endtask

  task automatic manual_transfer();
    data_t rd;
    logic  err;
    apb_write(reg_addr(REG_RX1_TX1), {8'h03, 24'h12_3456}, err);
    apb_write(reg_addr(REG_RX0_TX0), 32'h0, err);
    apb_write(reg_addr(REG_DIVIDER), 32'h0000_0002, err);
    apb_write(reg_addr(REG_SS), 32'h0000_0001, err);
    // 64 bits, GO_BSY and ie
    apb_write(reg_addr(REG_CTRL), 32'h0000_1140, err);
    do begin
      apb_read(reg_addr(REG_CTRL), rd, err);
    end while (rd[8]);
    apb_read(reg_addr(REG_RX0_TX0), rd, err);
    check_value("prdata_o (RX0)", rd, flash_word(24'h12_3456));
    check_value("spi_irq_o", data_t'(spi_irq), 32'h1);
    // Any CTRL write drops the interrupt
    apb_write(reg_addr(REG_CTRL), 32'h0000_0040, err);
    check_value("spi_irq_o", data_t'(spi_irq), 32'h0);
    apb_write(reg_addr(REG_SS), 32'h0, err);
  endtask

  task automatic xip_read_check(input logic [23:0] off);
    data_t rd;
    logic  err;
    apb_read(FLASH_BASE_DEFAULT + addr_t'(off), rd, err);
    check_value("pslverr_o", data_t'(err), 32'h0);
    check_value("prdata_o", rd, flash_word(off));
    check_value("spi_ss_o", data_t'(spi_ss), 32'hFF);
  endtask

  task automatic xip_random_reads();
    data_t r;
    for (int n = 0; n < XIP_READS; n++) begin
      take_random_bits(24, r);
      xip_read_check(r[23:0]);
    end
  endtask

  task automatic error_responses();
    data_t rd;
    logic  err;
    // Flash window is read only
    apb_write(FLASH_BASE_DEFAULT + 32'h100, 32'hDEAD_BEEF, err);
    check_value("pslverr_o", data_t'(err), 32'h1);
    apb_read(32'h2000_0000, rd, err);
    check_value("pslverr_o", data_t'(err), 32'h1);
    apb_write(32'h0000_0040, 32'h1, err);
    check_value("pslverr_o", data_t'(err), 32'h1);
    // Bridge recovers
    xip_read_check(24'h00_ABCD);
  endtask

  initial begin
    reset      = 1'b1;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    pstrb      = '0;
    lfsr_state = 16'd95;
    repeat (16) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    after_reset_state();
    register_access();
    manual_transfer();
    xip_random_reads();
    error_responses();
    $display(">>> PASS");
    $finish;
  end

endmodule

/* spi_xip.f */
src/spi_bus_pkg.sv
src/spi_core_pkg.sv
src/spi_shift_engine.sv
src/spi_master_wb.sv
src/apb_xip_bridge.sv
src/spi_xip_top.sv
testbench/spi_flash_model.sv
testbench/spi_xip_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= spi_xip_tb
FILELIST  ?= spi_xip.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF -- '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
